// ==== Makefile ====
# Verilator build and run of the shared multi-queue FIFO testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module shfifo_tb -o Vshfifo_tb
	./obj_dir/Vshfifo_tb | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
source/shfifo_pkg.sv
source/shfifo_freelist.sv
source/shfifo_ram.sv
source/shfifo_queue_ctrl.sv
source/shfifo_top.sv
verification/shfifo_chk.sv
verification/shfifo_tb.sv

// ==== source/shfifo_freelist.sv ====
// ----------------------------------------------------------
// Freelist: hands out free storage addresses, takes back
// released ones and keeps a running free count
// ----------------------------------------------------------
`timescale 1ns/1ps

module shfifo_freelist (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  // Allocation side
  input  logic [shfifo_pkg::NUM_WRITE_PORTS-1:0]               alloc_take,
  output shfifo_pkg::addr_t [shfifo_pkg::NUM_WRITE_PORTS-1:0]  alloc_addr,
  // Deallocation side, one bit per storage entry
  input  logic [shfifo_pkg::DEPTH-1:0]                         release_mask,
  output shfifo_pkg::count_t                                   free_count
);

  // One bit per entry, set while the entry is free
  logic [shfifo_pkg::DEPTH-1:0] free_bits;
  logic [shfifo_pkg::DEPTH-1:0] free_bits_nxt;
  logic [shfifo_pkg::DEPTH-1:0] taken_mask;

  shfifo_pkg::count_t count_nxt;

  logic first_found;
  logic second_found;

  // Lowest free entry goes to port 0, second lowest to port 1
  always_comb begin
    first_found = 1'b0;
    second_found = 1'b0;
    alloc_addr = '0;
    for (int i = 0; i < shfifo_pkg::DEPTH; i++) begin
      if (free_bits[i]) begin
        if (!first_found) begin
          alloc_addr[0] = shfifo_pkg::addr_t'(i);
          first_found = 1'b1;
        end else if (!second_found) begin
          alloc_addr[1] = shfifo_pkg::addr_t'(i);
          second_found = 1'b1;
        end
      end
    end
  end

  // Entries taken this cycle
  always_comb begin
    taken_mask = '0;
    for (int p = 0; p < shfifo_pkg::NUM_WRITE_PORTS; p++) begin
      if (alloc_take[p]) begin
        taken_mask[alloc_addr[p]] = 1'b1;
      end
    end
  end

  // Released entries are never free, so take and release never collide
  assign free_bits_nxt = (free_bits & ~taken_mask) | release_mask;

  // Running count: minus takes, plus releases
  always_comb begin
    count_nxt = free_count;
    for (int p = 0; p < shfifo_pkg::NUM_WRITE_PORTS; p++) begin
      count_nxt = count_nxt - shfifo_pkg::count_t'(alloc_take[p]);
    end
    for (int i = 0; i < shfifo_pkg::DEPTH; i++) begin
      count_nxt = count_nxt + shfifo_pkg::count_t'(release_mask[i]);
    end
  end

  // Whole pool is free after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      free_bits <= '1;
      free_count <= shfifo_pkg::count_t'(shfifo_pkg::DEPTH);
    end else begin
      free_bits <= free_bits_nxt;
      free_count <= count_nxt;
    end
  end

endmodule

// ==== source/shfifo_pkg.sv ====
// ----------------------------------------------------------
// Shared multi-queue FIFO: sizes, types and request structs
// ----------------------------------------------------------

package shfifo_pkg;

  // Port and queue counts
  localparam int NUM_WRITE_PORTS = 2;
  localparam int NUM_FIFOS = 4;

  // Shared storage pool
  localparam int DEPTH = 16;
  localparam int DATA_WIDTH = 8;

  // Derived widths
  localparam int ADDR_WIDTH = $clog2(DEPTH);
  localparam int FIFO_ID_WIDTH = $clog2(NUM_FIFOS);
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  // RAM write payload is sized for the widest payload, the data item
  localparam int RAM_PAYLOAD_WIDTH = DATA_WIDTH;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [FIFO_ID_WIDTH-1:0] fifo_id_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Occupancy and free counts, 0 to DEPTH inclusive
  typedef logic [COUNT_WIDTH-1:0] count_t;

  typedef logic [RAM_PAYLOAD_WIDTH-1:0] ram_payload_t;

  // One push request, target queue in the upper bits
  typedef struct packed {
    fifo_id_t fifo_id;
    data_t    data;
  } push_req_t;

  // One RAM write port
  // Narrower payloads sit in the low bits of the payload field
  typedef struct packed {
    logic         en;
    addr_t        addr;
    ram_payload_t payload;
  } ram_wr_t;

endpackage

// ==== source/shfifo_queue_ctrl.sv ====
// ----------------------------------------------------------
// Queue controller: linked-list heads, tails and counts for
// each logical queue, push linking, pop and address release
// ----------------------------------------------------------
`timescale 1ns/1ps

module shfifo_queue_ctrl (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  // External push side
  input  logic [shfifo_pkg::NUM_WRITE_PORTS-1:0]                push_valid,
  input  shfifo_pkg::push_req_t [shfifo_pkg::NUM_WRITE_PORTS-1:0] push_req,
  output logic [shfifo_pkg::NUM_WRITE_PORTS-1:0]                push_ready,
  // External pop side
  input  logic [shfifo_pkg::NUM_FIFOS-1:0]                      pop_ready,
  output logic [shfifo_pkg::NUM_FIFOS-1:0]                      pop_valid,
  output shfifo_pkg::data_t [shfifo_pkg::NUM_FIFOS-1:0]         pop_data,
  // Freelist
  input  shfifo_pkg::addr_t [shfifo_pkg::NUM_WRITE_PORTS-1:0]   alloc_addr,
  input  shfifo_pkg::count_t                                    free_count,
  output logic [shfifo_pkg::NUM_WRITE_PORTS-1:0]                alloc_take,
  output logic [shfifo_pkg::DEPTH-1:0]                          release_mask,
  // Data and pointer RAMs
  output shfifo_pkg::ram_wr_t [shfifo_pkg::NUM_WRITE_PORTS-1:0] data_wr,
  output shfifo_pkg::ram_wr_t [shfifo_pkg::NUM_WRITE_PORTS-1:0] next_wr,
  input  shfifo_pkg::data_t [shfifo_pkg::NUM_FIFOS-1:0]         data_rd,
  input  shfifo_pkg::addr_t [shfifo_pkg::NUM_FIFOS-1:0]         next_rd,
  output shfifo_pkg::addr_t [shfifo_pkg::NUM_FIFOS-1:0]         head_addr
);

  // Per-queue list state
  shfifo_pkg::addr_t [shfifo_pkg::NUM_FIFOS-1:0]  head;
  shfifo_pkg::addr_t [shfifo_pkg::NUM_FIFOS-1:0]  tail;
  shfifo_pkg::count_t [shfifo_pkg::NUM_FIFOS-1:0] fifo_count;

  shfifo_pkg::addr_t [shfifo_pkg::NUM_FIFOS-1:0]  head_nxt;
  shfifo_pkg::addr_t [shfifo_pkg::NUM_FIFOS-1:0]  tail_nxt;
  shfifo_pkg::count_t [shfifo_pkg::NUM_FIFOS-1:0] count_nxt;

  // Handshakes
  logic [shfifo_pkg::NUM_WRITE_PORTS-1:0] push_fire;
  logic [shfifo_pkg::NUM_FIFOS-1:0]       pop_fire;
  logic [shfifo_pkg::NUM_FIFOS-1:0][shfifo_pkg::NUM_WRITE_PORTS-1:0] push_hit;
  logic                                   same_fifo;

  // First and last address pushed into each queue this cycle
  shfifo_pkg::addr_t [shfifo_pkg::NUM_FIFOS-1:0] first_addr;
  shfifo_pkg::addr_t [shfifo_pkg::NUM_FIFOS-1:0] last_addr;

  // Room for both ports or neither, independent of push_valid
  assign push_ready = {shfifo_pkg::NUM_WRITE_PORTS{
                        free_count >= shfifo_pkg::count_t'(shfifo_pkg::NUM_WRITE_PORTS)}};
  assign push_fire = push_valid & push_ready;
  assign alloc_take = push_fire;

  // Both ports into one queue, port 0 goes first
  assign same_fifo = push_fire[0] && push_fire[1]
                     && (push_req[0].fifo_id == push_req[1].fifo_id);

  // Which port pushes which queue
  always_comb begin
    for (int f = 0; f < shfifo_pkg::NUM_FIFOS; f++) begin
      for (int p = 0; p < shfifo_pkg::NUM_WRITE_PORTS; p++) begin
        push_hit[f][p] = push_fire[p]
                         && (push_req[p].fifo_id == shfifo_pkg::fifo_id_t'(f));
      end
      first_addr[f] = push_hit[f][0] ? alloc_addr[0] : alloc_addr[1];
      last_addr[f] = push_hit[f][1] ? alloc_addr[1] : alloc_addr[0];
    end
  end

  // Data goes to the freshly allocated entry
  always_comb begin
    for (int p = 0; p < shfifo_pkg::NUM_WRITE_PORTS; p++) begin
      data_wr[p].en = push_fire[p];
      data_wr[p].addr = alloc_addr[p];
      data_wr[p].payload = shfifo_pkg::ram_payload_t'(push_req[p].data);
    end
  end

  // Pointer links
  always_comb begin
    // Port 0 links behind its queue's tail unless the queue is empty
    next_wr[0].en = push_fire[0] && (fifo_count[push_req[0].fifo_id] != '0);
    next_wr[0].addr = tail[push_req[0].fifo_id];
    next_wr[0].payload = shfifo_pkg::ram_payload_t'(alloc_addr[0]);
    // Port 1 links behind port 0 when both hit one queue
    if (same_fifo) begin
      next_wr[1].en = 1'b1;
      next_wr[1].addr = alloc_addr[0];
    end else begin
      next_wr[1].en = push_fire[1] && (fifo_count[push_req[1].fifo_id] != '0);
      next_wr[1].addr = tail[push_req[1].fifo_id];
    end
    next_wr[1].payload = shfifo_pkg::ram_payload_t'(alloc_addr[1]);
  end

  // Pop presentation straight from the head entry
  always_comb begin
    release_mask = '0;
    for (int f = 0; f < shfifo_pkg::NUM_FIFOS; f++) begin
      head_addr[f] = head[f];
      pop_valid[f] = (fifo_count[f] != '0);
      pop_data[f] = data_rd[f];
      pop_fire[f] = pop_valid[f] && pop_ready[f];
      // Popped head goes back to the freelist
      if (pop_fire[f]) begin
        release_mask[head[f]] = 1'b1;
      end
    end
  end

  // Next head, tail and count per queue
  always_comb begin
    for (int f = 0; f < shfifo_pkg::NUM_FIFOS; f++) begin
      head_nxt[f] = head[f];
      tail_nxt[f] = tail[f];
      count_nxt[f] = fifo_count[f]
                     + shfifo_pkg::count_t'(push_hit[f][0])
                     + shfifo_pkg::count_t'(push_hit[f][1])
                     - shfifo_pkg::count_t'(pop_fire[f]);
      if (|push_hit[f]) begin
        tail_nxt[f] = last_addr[f];
      end
      if (pop_fire[f]) begin
        // Last item leaves, a same-cycle push becomes the new head
        if (fifo_count[f] == shfifo_pkg::count_t'(1)) begin
          if (|push_hit[f]) begin
            head_nxt[f] = first_addr[f];
          end
        end else begin
          head_nxt[f] = next_rd[f];
        end
      end else if ((fifo_count[f] == '0) && (|push_hit[f])) begin
        head_nxt[f] = first_addr[f];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fifo_count <= '0;
      head <= '0;
      tail <= '0;
    end else begin
      fifo_count <= count_nxt;
      head <= head_nxt;
      tail <= tail_nxt;
    end
  end

endmodule

// ==== source/shfifo_ram.sv ====
// ----------------------------------------------------------
// Shared storage RAM: two write ports, one async read per queue
// ----------------------------------------------------------
`timescale 1ns/1ps

module shfifo_ram #(
  // Stored item, a data byte or a next-pointer
  parameter type payload_t = shfifo_pkg::data_t
) (
  input  logic                                                 clk,
  // Write ports, never the same address in one cycle
  input  shfifo_pkg::ram_wr_t [shfifo_pkg::NUM_WRITE_PORTS-1:0] wr,
  // One read per logical queue, at its head
  input  shfifo_pkg::addr_t [shfifo_pkg::NUM_FIFOS-1:0]         rd_addr,
  output payload_t [shfifo_pkg::NUM_FIFOS-1:0]                  rd_data
);

  localparam int PAYLOAD_WIDTH = $bits(payload_t);

  // Register array, no reset on storage
  payload_t mem [shfifo_pkg::DEPTH];

  // Payload sits in the low bits of the write field
  always_ff @(posedge clk) begin
    for (int p = 0; p < shfifo_pkg::NUM_WRITE_PORTS; p++) begin
      if (wr[p].en) begin
        mem[wr[p].addr] <= payload_t'(wr[p].payload[PAYLOAD_WIDTH-1:0]);
      end
    end
  end

  // Asynchronous reads
  always_comb begin
    for (int f = 0; f < shfifo_pkg::NUM_FIFOS; f++) begin
      rd_data[f] = mem[rd_addr[f]];
    end
  end

endmodule

// ==== source/shfifo_top.sv ====
// ----------------------------------------------------------
// Shared dynamic multi-queue FIFO, two push ports, four queues
// ----------------------------------------------------------
`timescale 1ns/1ps

module shfifo_top (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  // Push side
  input  logic [shfifo_pkg::NUM_WRITE_PORTS-1:0]                  push_valid,
  input  shfifo_pkg::push_req_t [shfifo_pkg::NUM_WRITE_PORTS-1:0] push_req,
  output logic [shfifo_pkg::NUM_WRITE_PORTS-1:0]                  push_ready,
  // Pop side
  input  logic [shfifo_pkg::NUM_FIFOS-1:0]                        pop_ready,
  output logic [shfifo_pkg::NUM_FIFOS-1:0]                        pop_valid,
  output shfifo_pkg::data_t [shfifo_pkg::NUM_FIFOS-1:0]           pop_data
);

  // Freelist links
  shfifo_pkg::addr_t [shfifo_pkg::NUM_WRITE_PORTS-1:0]   alloc_addr;
  logic [shfifo_pkg::NUM_WRITE_PORTS-1:0]                alloc_take;
  logic [shfifo_pkg::DEPTH-1:0]                          release_mask;
  shfifo_pkg::count_t                                    free_count;

  // RAM links
  shfifo_pkg::ram_wr_t [shfifo_pkg::NUM_WRITE_PORTS-1:0] data_wr;
  shfifo_pkg::ram_wr_t [shfifo_pkg::NUM_WRITE_PORTS-1:0] next_wr;
  shfifo_pkg::data_t [shfifo_pkg::NUM_FIFOS-1:0]         data_rd;
  shfifo_pkg::addr_t [shfifo_pkg::NUM_FIFOS-1:0]         next_rd;
  shfifo_pkg::addr_t [shfifo_pkg::NUM_FIFOS-1:0]         head_addr;

  shfifo_freelist freelist (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_take   (alloc_take),
    .alloc_addr   (alloc_addr),
    .release_mask (release_mask),
    .free_count   (free_count)
  );

  // Data items, read at each head
  shfifo_ram #(.payload_t(shfifo_pkg::data_t)) data_ram (
    .clk     (clk),
    .wr      (data_wr),
    .rd_addr (head_addr),
    .rd_data (data_rd)
  );

  // Next-pointers, read at each head
  shfifo_ram #(.payload_t(shfifo_pkg::addr_t)) next_ram (
    .clk     (clk),
    .wr      (next_wr),
    .rd_addr (head_addr),
    .rd_data (next_rd)
  );

  shfifo_queue_ctrl queue_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_req     (push_req),
    .push_ready   (push_ready),
    .pop_ready    (pop_ready),
    .pop_valid    (pop_valid),
    .pop_data     (pop_data),
    .alloc_addr   (alloc_addr),
    .free_count   (free_count),
    .alloc_take   (alloc_take),
    .release_mask (release_mask),
    .data_wr      (data_wr),
    .next_wr      (next_wr),
    .data_rd      (data_rd),
    .next_rd      (next_rd),
    .head_addr    (head_addr)
  );

endmodule

// ==== verification/shfifo_chk.sv ====
// ----------------------------------------------------------
// Handshake and occupancy assertions for the shared FIFO top
// ----------------------------------------------------------
`timescale 1ns/1ps

module shfifo_chk (
  input logic                                                    clk,
  input logic                                                    rst_n,
  input logic [shfifo_pkg::NUM_WRITE_PORTS-1:0]                  push_valid,
  input shfifo_pkg::push_req_t [shfifo_pkg::NUM_WRITE_PORTS-1:0] push_req,
  input logic [shfifo_pkg::NUM_WRITE_PORTS-1:0]                  push_ready,
  input logic [shfifo_pkg::NUM_FIFOS-1:0]                        pop_valid,
  input logic [shfifo_pkg::NUM_FIFOS-1:0]                        pop_ready,
  input shfifo_pkg::data_t [shfifo_pkg::NUM_FIFOS-1:0]           pop_data
);

  // Per-queue occupancy rebuilt from the port handshakes
  shfifo_pkg::count_t [shfifo_pkg::NUM_FIFOS-1:0] occ;
  shfifo_pkg::count_t [shfifo_pkg::NUM_FIFOS-1:0] occ_nxt;
  shfifo_pkg::count_t                             occ_total;

  always_comb begin
    occ_total = '0;
    for (int f = 0; f < shfifo_pkg::NUM_FIFOS; f++) begin
      occ_nxt[f] = occ[f] - shfifo_pkg::count_t'(pop_valid[f] && pop_ready[f]);
      for (int p = 0; p < shfifo_pkg::NUM_WRITE_PORTS; p++) begin
        if (push_valid[p] && push_ready[p]
            && (push_req[p].fifo_id == shfifo_pkg::fifo_id_t'(f))) begin
          occ_nxt[f] = occ_nxt[f] + shfifo_pkg::count_t'(1);
        end
      end
      occ_total = occ_total + occ[f];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      occ <= '0;
    end else begin
      occ <= occ_nxt;
    end
  end

  // Both ports see one shared ready
  a_ready_equal: assert property (@(posedge clk) disable iff (!rst_n)
    push_ready[0] == push_ready[1])
    else $error("push_ready bits differ");

  // Fewer than two free entries blocks every push
  a_no_room: assert property (@(posedge clk) disable iff (!rst_n)
    (occ_total > shfifo_pkg::count_t'(shfifo_pkg::DEPTH - shfifo_pkg::NUM_WRITE_PORTS))
    |-> (push_ready == '0))
    else $error("push_ready high with %0d entries in use", occ_total);

  for (genvar f = 0; f < shfifo_pkg::NUM_FIFOS; f++) begin : g_queue
    // Stalled head stays offered and unchanged
    a_pop_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (pop_valid[f] && !pop_ready[f]) |=> (pop_valid[f] && $stable(pop_data[f])))
      else $error("queue %0d dropped or changed its stalled head", f);

    // Empty queue offers nothing
    a_empty_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      (occ[f] == '0) |-> !pop_valid[f])
      else $error("queue %0d shows pop_valid with zero count", f);
  end

endmodule

// Watches the top-level ports only
bind shfifo_top shfifo_chk shfifo_chk_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .push_valid (push_valid),
  .push_req   (push_req),
  .push_ready (push_ready),
  .pop_valid  (pop_valid),
  .pop_ready  (pop_ready),
  .pop_data   (pop_data)
);

// ==== verification/shfifo_tb.sv ====
// ----------------------------------------------------------
// Testbench for the shared multi-queue FIFO: random traffic
// against a per-queue model, fill, recycling and drain
// ----------------------------------------------------------
`timescale 1ns/1ps

module shfifo_tb;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 3;
  localparam int FILL_CYCLES = 24;
  localparam int RANDOM_CYCLES = 600;
  localparam int DRAIN_CYCLES = 40;
  localparam int WATCHDOG_MARGIN = 50;
  localparam int NWP = shfifo_pkg::NUM_WRITE_PORTS;
  localparam int NF = shfifo_pkg::NUM_FIFOS;

  logic                          clk;
  logic                          rst_n;
  logic [NWP-1:0]                push_valid;
  shfifo_pkg::push_req_t [NWP-1:0] push_req;
  logic [NWP-1:0]                push_ready;
  logic [NF-1:0]                 pop_ready;
  logic [NF-1:0]                 pop_valid;
  shfifo_pkg::data_t [NF-1:0]    pop_data;

  // Model of the four logical queues
  shfifo_pkg::data_t model_q [NF][$];
  int pushed_total;
  int popped_total;

  // Push handshakes due at the next rising edge, found at the falling edge
  logic [NWP-1:0] push_fired;

  shfifo_top shfifo_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_req   (push_req),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Expected item at the head of queue f
  function automatic shfifo_pkg::data_t expected_front(input int f);
    return model_q[f][0];
  endfunction

  // Items held in all model queues
  function automatic int model_occupancy();
    int total;
    total = 0;
    for (int f = 0; f < NF; f++) begin
      total += model_q[f].size();
    end
    return total;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH time=%0t signal=%s actual=0x%0h expected=0x%0h",
               $time, name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // One cycle of stimulus, called right after a rising edge
  task automatic drive_inputs(input bit allow_push, input int unsigned pop_percent);
    shfifo_pkg::push_req_t req;
    for (int p = 0; p < NWP; p++) begin
      // Stalled request is held as it is
      if (!push_valid[p] || push_fired[p]) begin
        if (allow_push && ($urandom_range(99) < 70)) begin
          req.fifo_id = shfifo_pkg::fifo_id_t'($urandom_range(NF - 1));
          req.data = shfifo_pkg::data_t'($urandom);
          push_valid[p] <= 1'b1;
          push_req[p] <= req;
        end else begin
          push_valid[p] <= 1'b0;
        end
      end
    end
    for (int f = 0; f < NF; f++) begin
      pop_ready[f] <= ($urandom_range(99) < pop_percent);
    end
  endtask

  // Compare at the falling edge, then apply the coming handshakes to the model
  always @(negedge clk) begin
    int occ;
    logic [NWP-1:0] expected_ready;
    if (!rst_n) begin
      push_fired = '0;
    end else begin
      occ = model_occupancy();
      expected_ready = (occ <= shfifo_pkg::DEPTH - NWP) ? '1 : '0;
      check_equal("push_ready", 32'(push_ready), 32'(expected_ready));
      // Pops first, each against the model's front item
      for (int f = 0; f < NF; f++) begin
        check_equal($sformatf("pop_valid[%0d]", f), 32'(pop_valid[f]),
                    32'(model_q[f].size() != 0));
        if (pop_valid[f] && pop_ready[f]) begin
          check_equal($sformatf("pop_data[%0d]", f), 32'(pop_data[f]),
                      32'(expected_front(f)));
          void'(model_q[f].pop_front());
          popped_total++;
        end
      end
      // Port 0 is queued ahead of port 1
      for (int p = 0; p < NWP; p++) begin
        push_fired[p] = push_valid[p] && push_ready[p];
        if (push_fired[p]) begin
          model_q[push_req[p].fifo_id].push_back(push_req[p].data);
          pushed_total++;
        end
      end
    end
  end

  initial begin
    bit drain_done;
    void'($urandom(32'h0d209ce6));
    rst_n = 1'b0;
    push_valid = '0;
    push_req = '0;
    pop_ready = '0;
    pushed_total = 0;
    popped_total = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    // Fill with pops held off until push_ready drops
    repeat (FILL_CYCLES) begin
      @(posedge clk);
      drive_inputs(1'b1, 0);
    end
    // Pool has run out of room for a pair of pushes
    check_equal("fill_reached_full", 32'(model_occupancy() > shfifo_pkg::DEPTH - NWP),
                32'd1);
    // Mixed traffic, many passes through the pool
    repeat (RANDOM_CYCLES) begin
      @(posedge clk);
      drive_inputs(1'b1, 50);
    end
    // Drain: no new pushes, every queue popped each cycle
    drain_done = 1'b0;
    while (!drain_done) begin
      @(posedge clk);
      drain_done = (model_occupancy() == 0) && ((push_valid & ~push_fired) == '0);
      drive_inputs(1'b0, 100);
    end
    repeat (2) @(posedge clk);
    check_equal("popped_total", 32'(popped_total), 32'(pushed_total));
    // Every entry is back in the pool after the drain
    check_equal("free_count", 32'(shfifo_top_i.free_count), 32'(shfifo_pkg::DEPTH));
    if (pushed_total > 4 * shfifo_pkg::DEPTH) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Too few items pushed to recycle the pool: %0d", pushed_total);
      $display("Result: FAILED");
      $fatal(1, "too little traffic");
    end
  end

  // Bound on the whole run
  initial begin
    #((RESET_CYCLES + FILL_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES + WATCHDOG_MARGIN)
      * CLK_PERIOD);
    $display("Watchdog timeout: the run did not finish in time");
    $display("Result: FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule
